// File: hdl/fetchPkg.sv
package fetchPkg;

    // one word per address, the pc counts words and not bytes
    typedef logic [31:0] addrT;

    // raw instruction word as stored in the memory
    typedef logic [31:0] instrT;

    // next-pc choice made by the stage 1 mux
    typedef enum logic [1:0]
    {
        pcSeq     = 2'd0,  // pc + 1
        pcRestart = 2'd1,  // back to word zero
        pcBranch  = 2'd2,  // jump to target
        pcHold    = 2'd3   // refetch the current pc
    } pcSelT;

endpackage

// File: hdl/memPkg.sv
package memPkg;

    // log2 of the word count, 8 gives a 256 word memory
    localparam int DefaultAddrBits = 8;

    // instr2 value until the first real fetch
    // 32'h00000013 decodes as a harmless no-op
    localparam fetchPkg::instrT ResetInstr = 32'h00000013;

endpackage

// File: hdl/fetchIf.sv
interface fetchIf;

    fetchPkg::addrT  pc;       // stage 1 program counter
    logic            advance;  // pipeline moves at the next edge
    logic            pcValid;  // pc holds a real fetch address
    fetchPkg::instrT instr;    // registered read data from stage 2

    // program counter side
    modport pcSide
    (
        output pc,
        output advance,
        output pcValid
    );

    // memory side
    modport memSide
    (
        input  pc,
        input  advance,
        input  pcValid,
        output instr
    );

endinterface

// File: hdl/pcGen.sv
module pcGen #(
    parameter int MaxStall = 3
) (
    input  logic            clk,
    input  logic            nrst,
    input  logic            stall,
    input  fetchPkg::pcSelT pcSel,
    input  fetchPkg::addrT  target,
    fetchIf.pcSide          fi
);

    // counter just wide enough to reach MaxStall
    localparam int CntBits = (MaxStall > 0) ? $clog2(MaxStall + 1) : 1;

    typedef logic [CntBits-1:0] stallCntT;

    localparam stallCntT CntLimit = stallCntT'(MaxStall);

    fetchPkg::addrT pcQ;
    fetchPkg::addrT pcNext;
    logic           pcValidQ;
    stallCntT       stallCnt;
    logic           limitHit;
    logic           advance;
    logic           held;

    // watchdog: too many stalled cycles in a row force one step
    assign limitHit = (stallCnt >= CntLimit);

    // nothing moves until the first valid pc exists
    assign advance = pcValidQ && (!stall || limitHit);
    assign held    = pcValidQ && !advance;

    always_comb
    begin
        unique case (pcSel)
            fetchPkg::pcSeq:     pcNext = pcQ + 32'd1;
            fetchPkg::pcRestart: pcNext = '0;
            fetchPkg::pcBranch:  pcNext = target;
            fetchPkg::pcHold:    pcNext = pcQ;  // stage 2 still takes this pc again
            default:             pcNext = pcQ + 32'd1;
        endcase
    end

    // program counter, pcSel and target sampled on the same edge
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            pcQ <= '0;
        end
        else if (advance)
        begin
            pcQ <= pcNext;
        end
    end

    // goes high one cycle after reset is released
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            pcValidQ <= 1'b0;
        end
        else
        begin
            pcValidQ <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            stallCnt <= '0;
        end
        else if (advance)
        begin
            stallCnt <= '0;  // any step restarts the count
        end
        else if (held && (stallCnt != CntLimit))
        begin
            stallCnt <= stallCnt + 1'b1;  // saturates at the limit
        end
    end

    assign fi.pc      = pcQ;
    assign fi.advance = advance;
    assign fi.pcValid = pcValidQ;

endmodule

// File: hdl/fetchMem.sv
module fetchMem #(
    parameter int AddrBits = 8
) (
    input  logic            clk,
    input  logic            nrst,
    input  logic            debugWe,
    input  fetchPkg::addrT  debugAddr,
    input  fetchPkg::instrT debugInstr,
    fetchIf.memSide         fi,
    output fetchPkg::addrT  pc2,
    output fetchPkg::instrT instr2,
    output logic            valid2
);

    localparam int Depth = 2 ** AddrBits;

    // word index into the array, upper address bits are ignored
    typedef logic [AddrBits-1:0] memIdxT;

    fetchPkg::instrT mem [Depth];

    memIdxT          rdIdx;
    memIdxT          wrIdx;
    fetchPkg::instrT rdWord;
    fetchPkg::instrT instrQ;
    fetchPkg::addrT  pc2Q;
    logic            valid2Q;

    // both ports wrap modulo the depth
    assign rdIdx = fi.pc[AddrBits-1:0];
    assign wrIdx = debugAddr[AddrBits-1:0];

    // program load port
    // runs on every edge, also while stalled or in reset
    always_ff @(posedge clk)
    begin
        if (debugWe)
        begin
            mem[wrIdx] <= debugInstr;
        end
    end

    // a same-edge write lands after this read, so the old word comes out
    assign rdWord = mem[rdIdx];

    // read register, only loads when the pipe moves
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            instrQ <= memPkg::ResetInstr;
        end
        else if (fi.advance)
        begin
            instrQ <= rdWord;
        end
    end

    // pc2 and valid2 follow the read data edge for edge
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            pc2Q    <= '0;
            valid2Q <= 1'b0;
        end
        else if (fi.advance)
        begin
            pc2Q    <= fi.pc;
            valid2Q <= fi.pcValid;
        end
    end

    assign fi.instr = instrQ;

    // stage 2 outputs
    assign pc2    = pc2Q;
    assign instr2 = fi.instr;
    assign valid2 = valid2Q;

endmodule

// File: hdl/frontend.sv
module frontend #(
    parameter int AddrBits = memPkg::DefaultAddrBits,
    parameter int MaxStall = 3
) (
    input  logic            clk,
    input  logic            nrst,
    input  logic            stall,
    input  fetchPkg::pcSelT pcSel,
    input  fetchPkg::addrT  target,
    input  logic            debugWe,
    input  fetchPkg::addrT  debugAddr,
    input  fetchPkg::instrT debugInstr,
    output fetchPkg::addrT  pc2,
    output fetchPkg::instrT instr2,
    output logic            valid2
);

    // link between stage 1 and stage 2
    fetchIf fi ();

    // stage 1
    pcGen #(
        .MaxStall(MaxStall)
    ) pcGen_i (
        .clk   (clk),
        .nrst  (nrst),
        .stall (stall),
        .pcSel (pcSel),
        .target(target),
        .fi    (fi.pcSide)
    );

    // stage 2, debug writes go straight to the array
    fetchMem #(
        .AddrBits(AddrBits)
    ) fetchMem_i (
        .clk       (clk),
        .nrst      (nrst),
        .debugWe   (debugWe),
        .debugAddr (debugAddr),
        .debugInstr(debugInstr),
        .fi        (fi.memSide),
        .pc2       (pc2),
        .instr2    (instr2),
        .valid2    (valid2)
    );

endmodule

// File: tests/frontend_assert.sv
module frontendAssert #(
    parameter int MaxStall = 3
) (
    input logic            clk,
    input logic            nrst,
    input logic            stall,
    input fetchPkg::pcSelT pcSel,
    input logic            advance,
    input fetchPkg::addrT  pc2,
    input logic            valid2
);

    fetchPkg::addrT prevPc2;
    int             stuckCnt;  // stalled cycles in a row with pc2 unchanged
    logic           seqArmed;  // last advance used pcSeq

    int resetFails = 0;
    int stuckFails = 0;
    int seqFails   = 0;

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            prevPc2  <= '0;
            stuckCnt <= 0;
            seqArmed <= 1'b0;
        end
        else
        begin
            prevPc2 <= pc2;
            if (stall && pcSel != fetchPkg::pcHold && pc2 == prevPc2)
            begin
                stuckCnt <= stuckCnt + 1;
            end
            else
            begin
                stuckCnt <= 0;
            end
            if (advance)
            begin
                seqArmed <= (pcSel == fetchPkg::pcSeq);
            end
        end
    end

    resetLow: assert property (@(posedge clk) !nrst |-> !valid2)
    else
    begin
        $error("valid2 high while nrst is low");
        resetFails++;
    end

    // watchdog keeps the pipe moving
    stuckBound: assert property (@(posedge clk) disable iff (!nrst)
        stuckCnt <= MaxStall + 1)
    else
    begin
        $error("pc2 frozen longer than the stall limit");
        stuckFails++;
    end

    seqStep: assert property (@(posedge clk) disable iff (!nrst)
        advance && seqArmed && valid2 |=> pc2 == $past(pc2) + 32'd1)
    else
    begin
        $error("pc2 did not step by one after a sequential fetch");
        seqFails++;
    end

endmodule

bind frontend frontendAssert #(
    .MaxStall(MaxStall)
) assertChk (
    .clk    (clk),
    .nrst   (nrst),
    .stall  (stall),
    .pcSel  (pcSel),
    .advance(fi.advance),
    .pc2    (pc2),
    .valid2 (valid2)
);

// File: tests/frontendTb.sv
module frontendTb;

    localparam int Depth       = 2 ** memPkg::DefaultAddrBits;
    localparam int MaxStall    = 3;
    localparam int TestCycles  = 79;         // steps in the directed tests
    localparam int ResetCycles = Depth + 7;  // program load and reset hold
    localparam int CycleLimit  = 2 * TestCycles + ResetCycles;

    logic            clk;
    logic            nrst;
    logic            stall;
    fetchPkg::pcSelT pcSel;
    fetchPkg::addrT  target;
    logic            debugWe;
    fetchPkg::addrT  debugAddr;
    fetchPkg::instrT debugInstr;
    fetchPkg::addrT  pc2;
    fetchPkg::instrT instr2;
    logic            valid2;

    // reference model of the two stages
    fetchPkg::instrT prog [Depth];
    fetchPkg::addrT  refPc;
    logic            refPcValid;
    int              refStallCnt;
    fetchPkg::addrT  expPc2;
    fetchPkg::instrT expInstr2;
    logic            expValid2;

    // inputs seen by the coming edge
    logic            lastStall;
    fetchPkg::pcSelT lastSel;
    fetchPkg::addrT  lastTarget;
    logic            lastWe;
    fetchPkg::addrT  lastWaddr;
    fetchPkg::instrT lastWdata;

    logic [31:0] lfsr;
    int          addrErrors;
    int          instrErrors;
    int          flagErrors;
    int          assertErrors;
    int          cycleCnt;

    frontend dut_i (
        .clk       (clk),
        .nrst      (nrst),
        .stall     (stall),
        .pcSel     (pcSel),
        .target    (target),
        .debugWe   (debugWe),
        .debugAddr (debugAddr),
        .debugInstr(debugInstr),
        .pc2       (pc2),
        .instr2    (instr2),
        .valid2    (valid2)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps 32 22 2 1, one step per bit
    function automatic fetchPkg::instrT randBits(input int nBits);
        fetchPkg::instrT r;
        logic            fb;
        r = '0;
        for (int i = 0; i < nBits; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic checkAddr(input fetchPkg::addrT got, input fetchPkg::addrT want,
                             input string what);
        if (got !== want)
        begin
            addrErrors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic checkInstr(input fetchPkg::instrT got, input fetchPkg::instrT want,
                              input string what);
        if (got !== want)
        begin
            instrErrors++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic checkFlag(input logic got, input logic want, input string what);
        if (got !== want)
        begin
            flagErrors++;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    // one clock edge of the front end, predicted from the advance and pcSel rules
    function automatic void modelEdge();
        logic adv;
        adv = refPcValid && (!lastStall || refStallCnt >= MaxStall);
        if (adv)
        begin
            expPc2      = refPc;
            expInstr2   = prog[refPc[memPkg::DefaultAddrBits-1:0]];
            expValid2   = 1'b1;
            refStallCnt = 0;
            case (lastSel)
                fetchPkg::pcSeq:     refPc = refPc + 32'd1;
                fetchPkg::pcRestart: refPc = '0;
                fetchPkg::pcBranch:  refPc = lastTarget;
                default:             refPc = refPc;
            endcase
        end
        else if (refPcValid)
        begin
            refStallCnt++;
        end
        if (lastWe)
        begin
            prog[lastWaddr[memPkg::DefaultAddrBits-1:0]] = lastWdata;  // after the read
        end
        refPcValid = 1'b1;
    endfunction

    // drive one cycle, check what the previous inputs produced
    task automatic runCycle(input logic s, input fetchPkg::pcSelT sel, input fetchPkg::addrT t,
                            input logic we, input fetchPkg::addrT wa, input fetchPkg::instrT wd);
        @(posedge clk);
        modelEdge();
        stall      <= s;
        pcSel      <= sel;
        target     <= t;
        debugWe    <= we;
        debugAddr  <= wa;
        debugInstr <= wd;
        lastStall  = s;
        lastSel    = sel;
        lastTarget = t;
        lastWe     = we;
        lastWaddr  = wa;
        lastWdata  = wd;
        @(negedge clk);
        checkAddr(pc2, expPc2, "pc2");
        checkInstr(instr2, expInstr2, "instr2");
        checkFlag(valid2, expValid2, "valid2");
    endtask

    task automatic step(input logic s, input fetchPkg::pcSelT sel, input fetchPkg::addrT t);
        runCycle(s, sel, t, 1'b0, '0, '0);
    endtask

    task automatic loadProgram();
        for (int i = 0; i < Depth; i++)
        begin
            prog[i] = randBits(32);
            @(posedge clk);
            debugWe    <= 1'b1;
            debugAddr  <= fetchPkg::addrT'(i);
            debugInstr <= prog[i];
        end
        @(posedge clk);
        debugWe <= 1'b0;
    endtask

    task automatic resetState();
        repeat (5)
        begin
            @(negedge clk);
            checkAddr(pc2, '0, "pc2 in reset");
            checkInstr(instr2, memPkg::ResetInstr, "instr2 in reset");
            checkFlag(valid2, 1'b0, "valid2 in reset");
        end
        @(posedge clk);
        nrst        <= 1'b1;
        refPc       = '0;
        refPcValid  = 1'b0;
        refStallCnt = 0;
        expPc2      = '0;
        expInstr2   = memPkg::ResetInstr;
        expValid2   = 1'b0;
        lastStall   = 1'b0;
        lastSel     = fetchPkg::pcSeq;
        lastTarget  = '0;
        lastWe      = 1'b0;
        step(1'b0, fetchPkg::pcSeq, '0);  // pcValid rises, nothing moves yet
        step(1'b0, fetchPkg::pcSeq, '0);
        checkAddr(pc2, '0, "first pc2");
        checkInstr(instr2, prog[0], "first instr2");
        checkFlag(valid2, 1'b1, "first valid2");
    endtask

    task automatic sequentialFetch();
        repeat (20) step(1'b0, fetchPkg::pcSeq, '0);
        step(1'b0, fetchPkg::pcBranch, 32'h0000_00fa);  // run across the top of the array
        repeat (12) step(1'b0, fetchPkg::pcSeq, '0);
    endtask

    task automatic redirects();
        fetchPkg::addrT tgt;
        tgt = randBits(32);
        step(1'b0, fetchPkg::pcBranch, tgt);
        repeat (2) step(1'b0, fetchPkg::pcSeq, '0);
        checkAddr(pc2, tgt, "pc2 after branch");
        step(1'b0, fetchPkg::pcSeq, '0);
        step(1'b0, fetchPkg::pcRestart, '0);
        repeat (3) step(1'b0, fetchPkg::pcSeq, '0);
        repeat (3) step(1'b0, fetchPkg::pcHold, '0);
        repeat (2) step(1'b0, fetchPkg::pcSeq, '0);
    endtask

    task automatic stallWatchdog();
        for (int len = 1; len <= 3; len++)
        begin
            repeat (len) step(1'b1, fetchPkg::pcSeq, '0);
            repeat (2) step(1'b0, fetchPkg::pcSeq, '0);
        end
        repeat (10) step(1'b1, fetchPkg::pcSeq, '0);  // watchdog forces a step every 4th
        repeat (3) step(1'b0, fetchPkg::pcSeq, '0);
    endtask

    task automatic debugRewrite();
        fetchPkg::addrT  wa;
        fetchPkg::instrT wd;
        wa = randBits(memPkg::DefaultAddrBits);
        wd = randBits(32);
        runCycle(1'b0, fetchPkg::pcSeq, '0, 1'b1, wa, wd);  // fetch keeps running
        step(1'b0, fetchPkg::pcBranch, wa);
        repeat (2) step(1'b0, fetchPkg::pcSeq, '0);
        checkInstr(instr2, wd, "rewritten word");
        step(1'b0, fetchPkg::pcSeq, '0);
    endtask

    initial
    begin
        cycleCnt = 0;
        while (cycleCnt < CycleLimit)
        begin
            @(posedge clk);
            cycleCnt++;
        end
        $display("timeout: the tests did not finish within %0d cycles", CycleLimit);
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        lfsr        = 32'ha641;
        addrErrors  = 0;
        instrErrors = 0;
        flagErrors  = 0;
        nrst        = 1'b0;
        stall       = 1'b0;
        pcSel       = fetchPkg::pcSeq;
        target      = '0;
        debugWe     = 1'b0;
        debugAddr   = '0;
        debugInstr  = '0;
        loadProgram();
        resetState();
        sequentialFetch();
        redirects();
        stallWatchdog();
        debugRewrite();
        step(1'b0, fetchPkg::pcSeq, '0);  // last inputs still need a check
        assertErrors = dut_i.assertChk.resetFails + dut_i.assertChk.stuckFails
                     + dut_i.assertChk.seqFails;
        $display("errors: %0d addr, %0d instr, %0d flag, %0d assertion",
                 addrErrors, instrErrors, flagErrors, assertErrors);
        if (addrErrors + instrErrors + flagErrors + assertErrors == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
hdl/fetchPkg.sv
hdl/memPkg.sv
hdl/fetchIf.sv
hdl/pcGen.sv
hdl/fetchMem.sv
hdl/frontend.sv
tests/frontend_assert.sv
tests/frontendTb.sv

// File: Makefile
TOP := frontendTb

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f sim.f
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
